// File: files.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/memoryWriteback.sv
rtl/processor.sv
sim/processorTb.sv

// File: sim/processorTb.sv
// Processor directed testbench
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module processorTb;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 5;
	localparam int LoopN = 5;
	localparam int TestCount = 6;
	// full program store run LoopN+1 times per test, plus load and readback
	localparam int WatchdogNs =
		TestCount * (`CPU_IMEM_DEPTH * (LoopN + 1) + 200) * ClkPeriod + 2000;

	logic clk;
	logic rst;
	logic progWe;
	cpuPkg::pcT progAddr;
	cpuPkg::wordT progData;
	cpuPkg::regAddrT dbgAddr;
	cpuPkg::pcT pc;
	logic halted;
	cpuPkg::wordT cyclesConsumed;
	cpuPkg::wordT dbgData;

	cpuPkg::wordT prog [`CPU_IMEM_DEPTH];
	cpuPkg::wordT model [`CPU_REG_COUNT];
	int progLen;
	int errors;

	processor i_dut (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.dbgAddr(dbgAddr), .pc(pc), .halted(halted), .cyclesConsumed(cyclesConsumed),
		.dbgData(dbgData)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// empty program, all registers expected zero
	task automatic startProgram();
		progLen = 0;
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			model[i] = '0;
		end
	endtask

	task automatic appendWord(input cpuPkg::wordT w);
		prog[progLen] = w;
		progLen++;
	endtask

	function automatic cpuPkg::wordT signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic cpuPkg::wordT encodeI(input cpuPkg::opcodeT op,
			input cpuPkg::regAddrT rs, input cpuPkg::regAddrT rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// R-type results as the ISA defines them, slt signed
	function automatic cpuPkg::wordT rTypeRule(input cpuPkg::functT fn,
			input cpuPkg::wordT a, input cpuPkg::wordT b);
		case (fn)
			cpuPkg::fnAdd: return a + b;
			cpuPkg::fnSub: return a - b;
			cpuPkg::fnAnd: return a & b;
			cpuPkg::fnOr: return a | b;
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	task automatic addImm(input cpuPkg::regAddrT rt, input cpuPkg::regAddrT rs,
			input logic [15:0] imm);
		appendWord(encodeI(cpuPkg::opAddi, rs, rt, imm));
		if (rt != 0) model[rt] = model[rs] + signExtend(imm);
	endtask

	task automatic regOp(input cpuPkg::functT fn, input cpuPkg::regAddrT rd,
			input cpuPkg::regAddrT rs, input cpuPkg::regAddrT rt);
		appendWord({cpuPkg::opRType, rs, rt, rd, 5'd0, fn});
		if (rd != 0) model[rd] = rTypeRule(fn, model[rs], model[rt]);
	endtask

	task automatic memOp(input cpuPkg::opcodeT op, input cpuPkg::regAddrT rt,
			input cpuPkg::regAddrT rs, input logic [15:0] imm);
		appendWord(encodeI(op, rs, rt, imm));
	endtask

	task automatic branchEq(input cpuPkg::regAddrT rs, input cpuPkg::regAddrT rt,
			input logic [15:0] imm);
		appendWord(encodeI(cpuPkg::opBeq, rs, rt, imm));
	endtask

	task automatic endProgram();
		appendWord({cpuPkg::opHlt, 26'd0});
	endtask

	// program written while reset is held, at least ResetCycles long
	task automatic loadProgram();
		@(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < progLen || i < ResetCycles; i++) begin
			@(posedge clk);
			progWe <= (i < progLen);
			progAddr <= cpuPkg::pcT'(i);
			progData <= prog[i];
		end
		@(posedge clk);
		progWe <= 1'b0;
		rst <= 1'b1;
	endtask

	task automatic runToHalt(input string name, input int bound);
		int n;
		n = 0;
		while (!halted && n < bound) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			$display("%s: the processor did not halt within %0d cycles", name, bound);
			errors++;
		end
	endtask

	task automatic checkWord(input string name, input cpuPkg::wordT expected,
			input cpuPkg::wordT actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkPc(input string name, input cpuPkg::pcT expected,
			input cpuPkg::pcT actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic readReg(input cpuPkg::regAddrT r, output cpuPkg::wordT value);
		@(posedge clk);
		dbgAddr <= r;
		@(negedge clk);
		value = dbgData;
	endtask

	task automatic checkRegs(input string name);
		cpuPkg::wordT value;
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			readReg(cpuPkg::regAddrT'(i), value);
			checkWord($sformatf("%s r%0d", name, i), model[i], value);
		end
	endtask

	task automatic resetState();
		cpuPkg::wordT value;
		startProgram();
		endProgram();
		loadProgram();
		// first edge with reset released has not arrived yet
		@(negedge clk);
		checkPc("resetState pc", '0, pc);
		checkWord("resetState halted", '0, cpuPkg::wordT'(halted));
		checkWord("resetState cycles", '0, cyclesConsumed);
		for (int i = 0; i < 6; i++) begin
			readReg(cpuPkg::regAddrT'(i), value);
			checkWord($sformatf("resetState r%0d", i), '0, value);
		end
	endtask

	task automatic aluOps();
		startProgram();
		addImm(1, 0, 16'd100);
		addImm(2, 0, 16'hfff9);
		addImm(3, 0, 16'h0f0f);
		regOp(cpuPkg::fnAdd, 4, 1, 2);
		regOp(cpuPkg::fnSub, 5, 1, 2);
		regOp(cpuPkg::fnAnd, 6, 1, 3);
		regOp(cpuPkg::fnOr, 7, 1, 3);
		// negative against positive both ways
		regOp(cpuPkg::fnSlt, 8, 2, 1);
		regOp(cpuPkg::fnSlt, 9, 1, 2);
		endProgram();
		loadProgram();
		runToHalt("aluOps", progLen * 2);
		checkRegs("aluOps");
	endtask

	task automatic memoryRoundTrip();
		startProgram();
		addImm(1, 0, 16'd1234);
		addImm(2, 0, 16'hfdd5);
		addImm(3, 0, 16'd16);
		memOp(cpuPkg::opSw, 1, 3, 16'd4);
		memOp(cpuPkg::opSw, 2, 3, 16'hfffe);
		memOp(cpuPkg::opLw, 4, 3, 16'd4);
		memOp(cpuPkg::opLw, 5, 3, 16'hfffe);
		endProgram();
		model[4] = model[1];
		model[5] = model[2];
		loadProgram();
		runToHalt("memoryRoundTrip", progLen * 2);
		checkRegs("memoryRoundTrip");
	endtask

	task automatic branchLoop();
		int expectCycles;
		startProgram();
		addImm(1, 0, 16'(LoopN));
		addImm(2, 0, 16'd0);
		addImm(3, 0, 16'd1);
		// loop head at word 3, leaves for word 7 once r1 is zero
		branchEq(1, 0, 16'd3);
		regOp(cpuPkg::fnSub, 1, 1, 3);
		addImm(2, 2, 16'd2);
		branchEq(0, 0, 16'hfffc);
		// r1 is 0 and r3 is 1 here, so never taken
		branchEq(1, 3, 16'd1);
		addImm(4, 0, 16'd9);
		endProgram();
		model[1] = '0;
		model[2] = cpuPkg::wordT'(2 * LoopN);
		// setup, four per pass, exit beq, beq, addi, hlt
		expectCycles = 3 + 4 * LoopN + 4;
		loadProgram();
		runToHalt("branchLoop", progLen * (LoopN + 1));
		checkPc("branchLoop pc", cpuPkg::pcT'(progLen - 1), pc);
		checkWord("branchLoop cycles", cpuPkg::wordT'(expectCycles), cyclesConsumed);
		checkRegs("branchLoop");
	endtask

	task automatic haltAndZero();
		cpuPkg::pcT pcAtHalt;
		cpuPkg::wordT cyclesAtHalt;
		startProgram();
		addImm(0, 0, 16'd77);
		addImm(1, 0, 16'd5);
		regOp(cpuPkg::fnAdd, 0, 1, 1);
		addImm(2, 1, 16'd3);
		endProgram();
		loadProgram();
		runToHalt("haltAndZero", progLen * 2);
		pcAtHalt = pc;
		cyclesAtHalt = cyclesConsumed;
		checkWord("haltAndZero cycles", cpuPkg::wordT'(progLen), cyclesConsumed);
		checkRegs("haltAndZero");
		repeat (10) @(negedge clk);
		checkPc("haltAndZero pc frozen", pcAtHalt, pc);
		checkWord("haltAndZero cycles frozen", cyclesAtHalt, cyclesConsumed);
		checkRegs("haltAndZero frozen");
	endtask

	task automatic randomArithmetic();
		cpuPkg::functT fnList [5] = '{cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
			cpuPkg::fnOr, cpuPkg::fnSlt};
		startProgram();
		for (int i = 1; i <= 8; i++) begin
			addImm(cpuPkg::regAddrT'(i), cpuPkg::regAddrT'($urandom % i), 16'($urandom));
		end
		for (int i = 0; i < 16; i++) begin
			regOp(fnList[$urandom % 5], cpuPkg::regAddrT'(1 + $urandom % 10),
				cpuPkg::regAddrT'($urandom % 11), cpuPkg::regAddrT'($urandom % 11));
		end
		endProgram();
		loadProgram();
		runToHalt("randomArithmetic", progLen * 2);
		checkRegs("randomArithmetic");
	endtask

	initial begin
		void'($urandom(16));
		errors = 0;
		rst = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		dbgAddr = '0;
		resetState();
		aluOps();
		memoryRoundTrip();
		branchLoop();
		haltAndZero();
		randomArithmetic();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("Watchdog expired after %0d ns before the tests finished", WatchdogNs);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/processor.sv
// Single-cycle processor top
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module processor (
	input wire logic clk,
	input wire logic rst,
	input wire logic progWe,
	input wire cpuPkg::pcT progAddr,
	input wire cpuPkg::wordT progData,
	input wire cpuPkg::regAddrT dbgAddr,
	output cpuPkg::pcT pc,
	output logic halted,
	output cpuPkg::wordT cyclesConsumed,
	output cpuPkg::wordT dbgData
);

	cpuPkg::wordT instruction;
	cpuPkg::opcodeT opcode;
	cpuPkg::functT funct;
	cpuPkg::regAddrT rs;
	cpuPkg::regAddrT rt;
	cpuPkg::regAddrT rd;
	cpuPkg::regAddrT writeReg;
	cpuPkg::wordT extImm;
	cpuPkg::wordT readData1;
	cpuPkg::wordT readData2;
	cpuPkg::wordT operandB;
	cpuPkg::wordT aluResult;
	cpuPkg::wordT writeData;
	cpuPkg::aluOpT aluOp;
	logic regDst;
	logic aluSrc;
	logic branch;
	logic memWrite;
	logic memToReg;
	logic regWrite;
	logic halt;
	logic zero;
	logic branchTaken;

	// field extraction
	assign opcode = cpuPkg::opcodeT'(instruction[31:26]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign funct = cpuPkg::functT'(instruction[5:0]);
	assign extImm = {{(`CPU_DATA_WIDTH-16){instruction[15]}}, instruction[15:0]};

	// rd for R-type, rt for immediates and loads
	assign writeReg = regDst ? rd : rt;
	assign operandB = aluSrc ? extImm : readData2;
	assign branchTaken = branch & zero;

	fetchUnit u_fetch (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.branchTaken(branchTaken), .branchOffset(extImm), .halt(halt),
		.pc(pc), .instruction(instruction), .halted(halted)
	);

	controlUnit u_control (
		.opcode(opcode), .funct(funct), .regDst(regDst), .aluSrc(aluSrc), .branch(branch),
		.memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite), .halt(halt),
		.aluOp(aluOp)
	);

	registerFile u_regs (
		.clk(clk), .rst(rst), .writeEnable(regWrite & ~halted),
		.readAddr1(rs), .readAddr2(rt), .writeAddr(writeReg), .writeData(writeData),
		.dbgAddr(dbgAddr), .readData1(readData1), .readData2(readData2), .dbgData(dbgData)
	);

	alu u_alu (
		.operandA(readData1), .operandB(operandB), .aluOp(aluOp),
		.result(aluResult), .zero(zero)
	);

	memoryWriteback u_mem (
		.clk(clk), .memWrite(memWrite), .memToReg(memToReg), .address(aluResult),
		.storeData(readData2), .aluResult(aluResult), .writeData(writeData)
	);

	// counts every executed instruction, hlt included
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cyclesConsumed <= '0;
		end else if (!halted) begin
			cyclesConsumed <= cyclesConsumed + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/memoryWriteback.sv
// Data memory and write-back
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module memoryWriteback (
	input wire logic clk,
	input wire logic memWrite,
	input wire logic memToReg,
	input wire cpuPkg::wordT address,
	input wire cpuPkg::wordT storeData,
	input wire cpuPkg::wordT aluResult,
	output cpuPkg::wordT writeData
);

	localparam int DmemAddrWidth = $clog2(`CPU_DMEM_DEPTH);

	cpuPkg::wordT dataMem [`CPU_DMEM_DEPTH];
	logic [DmemAddrWidth-1:0] wordAddr;
	cpuPkg::wordT loadData;

	// word addressed, upper address bits ignored
	assign wordAddr = address[DmemAddrWidth-1:0];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			dataMem[wordAddr] <= storeData;
		end
	end

	assign loadData = dataMem[wordAddr];

	// lw takes the memory word, everything else the ALU result
	assign writeData = memToReg ? loadData : aluResult;

endmodule

`default_nettype wire

// File: rtl/alu.sv
// Arithmetic logic unit
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire cpuPkg::wordT operandA,
	input wire cpuPkg::wordT operandB,
	input wire cpuPkg::aluOpT aluOp,
	output cpuPkg::wordT result,
	output logic zero
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: result = operandA + operandB;
			cpuPkg::aluSub: result = operandA - operandB;
			cpuPkg::aluAnd: result = operandA & operandB;
			cpuPkg::aluOr: result = operandA | operandB;
			cpuPkg::aluSlt: result = cpuPkg::wordT'(lessThan);
			default: result = '0;
		endcase
	end

	// beq relies on this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
// Register file with debug port
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module registerFile (
	input wire logic clk,
	input wire logic rst,
	input wire logic writeEnable,
	input wire cpuPkg::regAddrT readAddr1,
	input wire cpuPkg::regAddrT readAddr2,
	input wire cpuPkg::regAddrT writeAddr,
	input wire cpuPkg::wordT writeData,
	input wire cpuPkg::regAddrT dbgAddr,
	output cpuPkg::wordT readData1,
	output cpuPkg::wordT readData2,
	output cpuPkg::wordT dbgData
);

	cpuPkg::wordT regs [`CPU_REG_COUNT];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeAddr != '0)) begin
			// register 0 is never written so it stays zero
			regs[writeAddr] <= writeData;
		end
	end

	// asynchronous reads
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];
	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
// Main decoder
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire cpuPkg::opcodeT opcode,
	input wire cpuPkg::functT funct,
	output logic regDst,
	output logic aluSrc,
	output logic branch,
	output logic memWrite,
	output logic memToReg,
	output logic regWrite,
	output logic halt,
	output cpuPkg::aluOpT aluOp
);

	always_comb begin
		// no-op unless decoded below
		regDst = 1'b0;
		aluSrc = 1'b0;
		branch = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		halt = 1'b0;
		aluOp = cpuPkg::aluAdd;

		case (opcode)
			cpuPkg::opRType: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
					// unknown funct writes nothing
					default: regWrite = 1'b0;
				endcase
			end
			cpuPkg::opAddi: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opLw: begin
				aluSrc = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opSw: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			cpuPkg::opBeq: begin
				// compare by subtraction, zero flag decides
				branch = 1'b1;
				aluOp = cpuPkg::aluSub;
			end
			cpuPkg::opHlt: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
// Instruction fetch unit
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetchUnit (
	input wire logic clk,
	input wire logic rst,
	input wire logic progWe,
	input wire cpuPkg::pcT progAddr,
	input wire cpuPkg::wordT progData,
	input wire logic branchTaken,
	input wire cpuPkg::wordT branchOffset,
	input wire logic halt,
	output cpuPkg::pcT pc,
	output cpuPkg::wordT instruction,
	output logic halted
);

	cpuPkg::wordT instrMem [`CPU_IMEM_DEPTH];
	cpuPkg::pcT pcPlus1;
	cpuPkg::pcT branchTarget;
	cpuPkg::pcT nextPc;

	// sequential and branch targets
	assign pcPlus1 = pc + 1'b1;
	// offset wraps within the small instruction space
	assign branchTarget = pcPlus1 + cpuPkg::pcT'(branchOffset);

	always_comb begin
		if (halted || halt) begin
			// a hlt at pc freezes the fetch on the same edge
			nextPc = pc;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else begin
			pc <= nextPc;
			// sticky until reset
			halted <= halted | halt;
		end
	end

	// program load port
	always_ff @(posedge clk) begin
		if (progWe) begin
			instrMem[progAddr] <= progData;
		end
	end

	assign instruction = instrMem[pc];

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
// CPU shared types
`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] wordT;
	typedef logic [`CPU_PC_WIDTH-1:0] pcT;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddrT;

	// primary opcodes, bits 31 to 26
	typedef enum logic [5:0] {
		opRType = 6'd0,
		opBeq = 6'd4,
		opAddi = 6'd8,
		opLw = 6'd35,
		opSw = 6'd43,
		opHlt = 6'd63
	} opcodeT;

	// R-type function codes, bits 5 to 0
	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnSlt = 6'd42
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

endpackage

`default_nettype wire

// File: rtl/cpu_params.svh
// CPU width and depth macros
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data word width
`define CPU_DATA_WIDTH 32

// instruction address width
`define CPU_PC_WIDTH 6

// instruction words in the program store
`define CPU_IMEM_DEPTH 64

// data words, word addressed by the low ALU result bits
`define CPU_DMEM_DEPTH 256

// architectural registers
`define CPU_REG_COUNT 32

`endif
